/* src/fdiv_pkg.sv */
package fdiv_pkg;

  // ==============================
  // Single-precision field widths
  // ==============================

  localparam int FP_BITS = 32;
  localparam int EXP_BITS = 8;
  localparam int FRAC_BITS = 23;
  // Mantissa with the hidden one
  localparam int MANT_BITS = 24;
  // Signed working exponent, room for overflow and underflow
  localparam int EXP_EXT_BITS = 10;
  localparam int EXP_BIAS = 127;

  // Integer bit, 23 fraction bits, guard and one extra bit
  // Also the number of divider steps
  localparam int QUOT_BITS = 26;

  // Positive quiet NaN
  localparam logic [FP_BITS-1:0] CANONICAL_NAN = 32'h7fc0_0000;

  // ==============================
  // Exception flags, fflags order
  // ==============================

  localparam int FLAG_BITS = 5;
  localparam int FLAG_NX = 0;
  localparam int FLAG_UF = 1;
  localparam int FLAG_OF = 2;
  localparam int FLAG_DZ = 3;
  localparam int FLAG_NV = 4;

  // Codes 5 to 7 are handled as RNE
  typedef enum logic [2:0] {
    RM_RNE = 3'd0,
    RM_RTZ = 3'd1,
    RM_RDN = 3'd2,
    RM_RUP = 3'd3,
    RM_RMM = 3'd4
  } round_mode_t;

  // Controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CLASSIFY,
    ST_SETUP,
    ST_DIVIDE,
    ST_NORMALIZE,
    ST_ROUND,
    ST_DONE
  } fdiv_state_t;

endpackage

/* src/fdiv_classify.sv */
module fdiv_classify (
  input  logic                                   i_clk,
  input  logic                                   i_rst,
  input  logic                                   i_en,
  input  logic [fdiv_pkg::FP_BITS-1:0]           i_op_a,
  input  logic [fdiv_pkg::FP_BITS-1:0]           i_op_b,
  output logic                                   o_sign,
  output logic signed [fdiv_pkg::EXP_EXT_BITS-1:0] o_exp_diff,
  output logic [fdiv_pkg::MANT_BITS-1:0]         o_mant_a,
  output logic [fdiv_pkg::MANT_BITS-1:0]         o_mant_b,
  output logic                                   o_is_special,
  output logic [fdiv_pkg::FP_BITS-1:0]           o_special_result,
  output logic [fdiv_pkg::FLAG_BITS-1:0]         o_special_flags
);

  localparam int EB = fdiv_pkg::EXP_BITS;
  localparam int FB = fdiv_pkg::FRAC_BITS;
  localparam int SB = fdiv_pkg::FP_BITS - 1;

  logic [EB-1:0] exp_a, exp_b;
  logic [FB-1:0] frac_a, frac_b;
  logic zero_a, zero_b, inf_a, inf_b, nan_a, nan_b, snan_a, snan_b;
  logic sign;
  logic signed [fdiv_pkg::EXP_EXT_BITS-1:0] exp_diff;
  logic spec_hit;
  logic [fdiv_pkg::FP_BITS-1:0] spec_res;
  logic [fdiv_pkg::FLAG_BITS-1:0] spec_flags;

  // ==============================
  // Operand fields
  // ==============================

  assign exp_a = i_op_a[FB +: EB];
  assign exp_b = i_op_b[FB +: EB];
  assign frac_a = i_op_a[FB-1:0];
  assign frac_b = i_op_b[FB-1:0];
  assign sign = i_op_a[SB] ^ i_op_b[SB];

  // Subnormals fall in with zero here
  assign zero_a = (exp_a == '0);
  assign zero_b = (exp_b == '0);
  assign inf_a = (exp_a == '1) && (frac_a == '0);
  assign inf_b = (exp_b == '1) && (frac_b == '0);
  assign nan_a = (exp_a == '1) && (frac_a != '0);
  assign nan_b = (exp_b == '1) && (frac_b != '0);
  // Signaling NaN has the quiet bit clear
  assign snan_a = nan_a && !frac_a[FB-1];
  assign snan_b = nan_b && !frac_b[FB-1];

  // Biased result exponent before normalization
  assign exp_diff = $signed({2'b00, exp_a}) - $signed({2'b00, exp_b})
                  + fdiv_pkg::EXP_EXT_BITS'(fdiv_pkg::EXP_BIAS);

  // ==============================
  // Special cases, first match wins
  // ==============================

  always_comb begin
    spec_hit = 1'b1;
    spec_res = fdiv_pkg::CANONICAL_NAN;
    spec_flags = '0;
    if (nan_a || nan_b) begin
      spec_flags[fdiv_pkg::FLAG_NV] = snan_a | snan_b;
    end else if ((inf_a && inf_b) || (zero_a && zero_b)) begin
      spec_flags[fdiv_pkg::FLAG_NV] = 1'b1;
    end else if (inf_a) begin
      spec_res = {sign, {EB{1'b1}}, {FB{1'b0}}};
    end else if (inf_b) begin
      spec_res = {sign, {SB{1'b0}}};
    end else if (zero_b) begin
      // Finite nonzero over zero
      spec_res = {sign, {EB{1'b1}}, {FB{1'b0}}};
      spec_flags[fdiv_pkg::FLAG_DZ] = 1'b1;
    end else if (zero_a) begin
      spec_res = {sign, {SB{1'b0}}};
    end else begin
      spec_hit = 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_is_special <= 1'b0;
    end else if (i_en) begin
      o_is_special <= spec_hit;
    end
  end

  // Payload registers
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      o_sign <= sign;
      o_exp_diff <= exp_diff;
      o_mant_a <= {~zero_a, frac_a};
      o_mant_b <= {~zero_b, frac_b};
      o_special_result <= spec_res;
      o_special_flags <= spec_flags;
    end
  end

endmodule

/* src/fdiv_mant_divider.sv */
module fdiv_mant_divider (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic                           i_start,
  input  logic [fdiv_pkg::MANT_BITS-1:0] i_mant_a,
  input  logic [fdiv_pkg::MANT_BITS-1:0] i_mant_b,
  output logic [fdiv_pkg::QUOT_BITS-1:0] o_quotient,
  output logic                           o_rem_nonzero,
  output logic                           o_done
);

  localparam int MB = fdiv_pkg::MANT_BITS;
  localparam int QB = fdiv_pkg::QUOT_BITS;
  localparam int CNT_BITS = $clog2(QB);

  logic busy;
  logic [CNT_BITS-1:0] step_cnt;
  // One bit wider than the mantissa, remainder stays below twice the divisor
  logic [MB:0] rem_q, divisor_q;
  logic [MB:0] rem_src, divisor_src, rem_sub, rem_next;
  logic [QB-1:0] quot_q;
  logic q_bit;

  // ==============================
  // One restoring step per cycle
  // ==============================

  // The start cycle already takes the first step on the fresh operands
  assign rem_src = i_start ? {1'b0, i_mant_a} : rem_q;
  assign divisor_src = i_start ? {1'b0, i_mant_b} : divisor_q;

  always_comb begin
    q_bit = (rem_src >= divisor_src);
    rem_sub = q_bit ? (rem_src - divisor_src) : rem_src;
    // Top bit is clear after the compare, doubling cannot overflow
    rem_next = {rem_sub[MB-1:0], 1'b0};
  end

  // Last step happens on the edge that ends the done cycle
  assign o_done = busy && (step_cnt == CNT_BITS'(QB - 1));
  assign o_quotient = quot_q;
  assign o_rem_nonzero = (rem_q != '0);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy <= 1'b0;
      step_cnt <= '0;
    end else if (i_start) begin
      busy <= 1'b1;
      step_cnt <= CNT_BITS'(1);
    end else if (o_done) begin
      busy <= 1'b0;
      step_cnt <= '0;
    end else if (busy) begin
      step_cnt <= step_cnt + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      divisor_q <= {1'b0, i_mant_b};
    end
    if (i_start || busy) begin
      rem_q <= rem_next;
      quot_q <= {quot_q[QB-2:0], q_bit};
    end
  end

  // Controller must wait for the previous run
  a_no_start_busy: assert property (@(posedge i_clk) disable iff (i_rst)
    i_start |-> !busy);

endmodule

/* src/fdiv_round_pack.sv */
module fdiv_round_pack (
  input  logic                                     i_clk,
  input  logic                                     i_rst,
  input  logic                                     i_norm_en,
  input  logic                                     i_round_en,
  input  logic                                     i_sign,
  input  logic signed [fdiv_pkg::EXP_EXT_BITS-1:0] i_exp,
  input  logic [fdiv_pkg::QUOT_BITS-1:0]           i_quotient,
  input  logic                                     i_rem_nonzero,
  input  fdiv_pkg::round_mode_t                    i_rm,
  output logic [fdiv_pkg::FP_BITS-1:0]             o_result,
  output logic [fdiv_pkg::FLAG_BITS-1:0]           o_flags
);

  localparam int MB = fdiv_pkg::MANT_BITS;
  localparam int QB = fdiv_pkg::QUOT_BITS;
  localparam int XB = fdiv_pkg::EXP_EXT_BITS;
  localparam int EB = fdiv_pkg::EXP_BITS;
  localparam int FB = fdiv_pkg::FRAC_BITS;
  // Guard sits just below the kept mantissa
  localparam int GUARD_POS = QB - MB - 1;
  localparam logic signed [XB-1:0] EXP_OVF = XB'(255);

  logic [QB-1:0] quot_shift;
  logic signed [XB-1:0] exp_shift;
  logic [MB-1:0] mant_q;
  logic guard_q, sticky_q;
  logic signed [XB-1:0] exp_q;
  logic inc, inexact, to_max;
  logic [MB:0] mant_sum;
  logic [MB-1:0] mant_rnd;
  logic signed [XB-1:0] exp_rnd;
  logic [fdiv_pkg::FP_BITS-1:0] result;
  logic [fdiv_pkg::FLAG_BITS-1:0] flags;

  // ==============================
  // Normalize
  // ==============================

  // Quotient of two normal mantissas lies in [0.5, 2), one shift at most
  always_comb begin
    if (i_quotient[QB-1]) begin
      quot_shift = i_quotient;
      exp_shift = i_exp;
    end else begin
      quot_shift = {i_quotient[QB-2:0], 1'b0};
      exp_shift = i_exp - XB'(1);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_norm_en) begin
      mant_q <= quot_shift[QB-1 -: MB];
      guard_q <= quot_shift[GUARD_POS];
      sticky_q <= (|quot_shift[GUARD_POS-1:0]) | i_rem_nonzero;
      exp_q <= exp_shift;
    end
  end

  // ==============================
  // Round and pack
  // ==============================

  always_comb begin
    inexact = guard_q | sticky_q;
    case (i_rm)
      fdiv_pkg::RM_RTZ: inc = 1'b0;
      fdiv_pkg::RM_RDN: inc = i_sign & inexact;
      fdiv_pkg::RM_RUP: inc = ~i_sign & inexact;
      fdiv_pkg::RM_RMM: inc = guard_q;
      // RNE and the reserved codes
      default: inc = guard_q & (sticky_q | mant_q[0]);
    endcase

    mant_sum = {1'b0, mant_q} + {{MB{1'b0}}, inc};
    // Carry out of the mantissa bumps the exponent
    if (mant_sum[MB]) begin
      mant_rnd = mant_sum[MB:1];
      exp_rnd = exp_q + XB'(1);
    end else begin
      mant_rnd = mant_sum[MB-1:0];
      exp_rnd = exp_q;
    end

    // Largest finite value when rounding toward zero magnitude
    to_max = (i_rm == fdiv_pkg::RM_RTZ) || ((i_rm == fdiv_pkg::RM_RDN) && !i_sign)
          || ((i_rm == fdiv_pkg::RM_RUP) && i_sign);

    flags = '0;
    if (exp_rnd >= EXP_OVF) begin
      result = to_max ? {i_sign, {(EB-1){1'b1}}, 1'b0, {FB{1'b1}}}
                      : {i_sign, {EB{1'b1}}, {FB{1'b0}}};
      flags[fdiv_pkg::FLAG_OF] = 1'b1;
      flags[fdiv_pkg::FLAG_NX] = 1'b1;
    end else if (exp_rnd <= 0) begin
      // No subnormal results, flush to signed zero
      result = {i_sign, {(EB+FB){1'b0}}};
      flags[fdiv_pkg::FLAG_UF] = 1'b1;
      flags[fdiv_pkg::FLAG_NX] = 1'b1;
    end else begin
      result = {i_sign, exp_rnd[EB-1:0], mant_rnd[FB-1:0]};
      flags[fdiv_pkg::FLAG_NX] = inexact;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_round_en) begin
      o_result <= result;
      o_flags <= flags;
    end
  end

  // Holds only if the divider was fed normalized mantissas
  a_norm_msb: assert property (@(posedge i_clk) disable iff (i_rst)
    i_norm_en |=> mant_q[MB-1]);

endmodule

/* src/fdiv_ctrl.sv */
module fdiv_ctrl (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic                           i_valid,
  input  logic [fdiv_pkg::FP_BITS-1:0]   i_operand_a,
  input  logic [fdiv_pkg::FP_BITS-1:0]   i_operand_b,
  input  logic [2:0]                     i_rounding_mode,
  input  logic                           i_is_special,
  input  logic [fdiv_pkg::FP_BITS-1:0]   i_special_result,
  input  logic [fdiv_pkg::FLAG_BITS-1:0] i_special_flags,
  input  logic                           i_div_done,
  input  logic [fdiv_pkg::FP_BITS-1:0]   i_round_result,
  input  logic [fdiv_pkg::FLAG_BITS-1:0] i_round_flags,
  output logic [fdiv_pkg::FP_BITS-1:0]   o_op_a,
  output logic [fdiv_pkg::FP_BITS-1:0]   o_op_b,
  output fdiv_pkg::round_mode_t          o_rm,
  output logic                           o_classify_en,
  output logic                           o_div_start,
  output logic                           o_norm_en,
  output logic                           o_round_en,
  output logic [fdiv_pkg::FP_BITS-1:0]   o_result,
  output logic [fdiv_pkg::FLAG_BITS-1:0] o_flags,
  output logic                           o_valid,
  output logic                           o_stall
);

  fdiv_pkg::fdiv_state_t state_q, state_d;
  logic capture;

  // ==============================
  // State machine
  // ==============================

  always_comb begin
    state_d = state_q;
    case (state_q)
      fdiv_pkg::ST_IDLE: if (i_valid) state_d = fdiv_pkg::ST_CLASSIFY;
      fdiv_pkg::ST_CLASSIFY: state_d = fdiv_pkg::ST_SETUP;
      // Special pairs never touch the divider
      fdiv_pkg::ST_SETUP:
        state_d = i_is_special ? fdiv_pkg::ST_DONE : fdiv_pkg::ST_DIVIDE;
      fdiv_pkg::ST_DIVIDE: if (i_div_done) state_d = fdiv_pkg::ST_NORMALIZE;
      fdiv_pkg::ST_NORMALIZE: state_d = fdiv_pkg::ST_ROUND;
      fdiv_pkg::ST_ROUND: state_d = fdiv_pkg::ST_DONE;
      default: state_d = fdiv_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= fdiv_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Stage strobes
  assign capture = (state_q == fdiv_pkg::ST_IDLE) && i_valid;
  assign o_classify_en = (state_q == fdiv_pkg::ST_CLASSIFY);
  assign o_div_start = (state_q == fdiv_pkg::ST_SETUP) && !i_is_special;
  assign o_norm_en = (state_q == fdiv_pkg::ST_NORMALIZE);
  assign o_round_en = (state_q == fdiv_pkg::ST_ROUND);

  // Operands and mode held for the whole operation
  always_ff @(posedge i_clk) begin
    if (capture) begin
      o_op_a <= i_operand_a;
      o_op_b <= i_operand_b;
      o_rm <= fdiv_pkg::round_mode_t'(i_rounding_mode);
    end
  end

  // ==============================
  // Result registers and handshake
  // ==============================

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_result <= '0;
      o_flags <= '0;
      o_valid <= 1'b0;
    end else begin
      o_valid <= (state_q == fdiv_pkg::ST_DONE);
      if (state_q == fdiv_pkg::ST_DONE) begin
        o_result <= i_is_special ? i_special_result : i_round_result;
        o_flags <= i_is_special ? i_special_flags : i_round_flags;
      end
    end
  end

  // Stall from the first cycle of i_valid until the result pulse
  assign o_stall = ((state_q != fdiv_pkg::ST_IDLE) || i_valid) && !o_valid;

  a_valid_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
    o_valid |=> !o_valid);

endmodule

/* src/fdiv_top.sv */
module fdiv_top (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic                           i_valid,
  input  logic [fdiv_pkg::FP_BITS-1:0]   i_operand_a,
  input  logic [fdiv_pkg::FP_BITS-1:0]   i_operand_b,
  input  logic [2:0]                     i_rounding_mode,
  output logic [fdiv_pkg::FP_BITS-1:0]   o_result,
  output logic                           o_valid,
  output logic                           o_stall,
  output logic [fdiv_pkg::FLAG_BITS-1:0] o_flags
);

  logic [fdiv_pkg::FP_BITS-1:0] op_a, op_b, special_result, round_result;
  logic [fdiv_pkg::FLAG_BITS-1:0] special_flags, round_flags;
  fdiv_pkg::round_mode_t rm;
  logic classify_en, div_start, norm_en, round_en;
  logic is_special, sign, div_done, rem_nonzero;
  logic signed [fdiv_pkg::EXP_EXT_BITS-1:0] exp_diff;
  logic [fdiv_pkg::MANT_BITS-1:0] mant_a, mant_b;
  logic [fdiv_pkg::QUOT_BITS-1:0] quotient;

  fdiv_ctrl u_ctrl (
    .i_clk(i_clk), .i_rst(i_rst), .i_valid(i_valid),
    .i_operand_a(i_operand_a), .i_operand_b(i_operand_b),
    .i_rounding_mode(i_rounding_mode),
    .i_is_special(is_special), .i_special_result(special_result),
    .i_special_flags(special_flags), .i_div_done(div_done),
    .i_round_result(round_result), .i_round_flags(round_flags),
    .o_op_a(op_a), .o_op_b(op_b), .o_rm(rm),
    .o_classify_en(classify_en), .o_div_start(div_start),
    .o_norm_en(norm_en), .o_round_en(round_en),
    .o_result(o_result), .o_flags(o_flags), .o_valid(o_valid), .o_stall(o_stall)
  );

  fdiv_classify u_classify (
    .i_clk(i_clk), .i_rst(i_rst), .i_en(classify_en),
    .i_op_a(op_a), .i_op_b(op_b),
    .o_sign(sign), .o_exp_diff(exp_diff), .o_mant_a(mant_a), .o_mant_b(mant_b),
    .o_is_special(is_special), .o_special_result(special_result),
    .o_special_flags(special_flags)
  );

  fdiv_mant_divider u_divider (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(div_start),
    .i_mant_a(mant_a), .i_mant_b(mant_b),
    .o_quotient(quotient), .o_rem_nonzero(rem_nonzero), .o_done(div_done)
  );

  fdiv_round_pack u_round_pack (
    .i_clk(i_clk), .i_rst(i_rst), .i_norm_en(norm_en), .i_round_en(round_en),
    .i_sign(sign), .i_exp(exp_diff), .i_quotient(quotient),
    .i_rem_nonzero(rem_nonzero), .i_rm(rm),
    .o_result(round_result), .o_flags(round_flags)
  );

endmodule

/* tests/fdiv_ref.svh */
`ifndef FDIV_REF_SVH
`define FDIV_REF_SVH

// Pairs that take the short path, any zero, subnormal, infinite or NaN exponent
function automatic logic is_special_pair(input logic [31:0] a, input logic [31:0] b);
  return (a[30:23] == 8'h00) || (a[30:23] == 8'hff)
      || (b[30:23] == 8'h00) || (b[30:23] == 8'hff);
endfunction

// Expected {flags, result} of a / b under rounding mode rm
function automatic logic [36:0] divide_reference(input logic [31:0] a, input logic [31:0] b,
                                                 input logic [2:0] rm);
  logic sign;
  logic [7:0] ea;
  logic [7:0] eb;
  logic [22:0] fa;
  logic [22:0] fb;
  logic nan_a, nan_b, inf_a, inf_b, zero_a, zero_b;
  logic [63:0] num;
  logic [63:0] den;
  logic [63:0] quot;
  logic [63:0] rem;
  int exp_val;
  logic [23:0] mant;
  logic guard;
  logic sticky;
  logic inc;
  logic to_max;
  logic [24:0] sum;
  logic [4:0] flags;

  sign = a[31] ^ b[31];
  ea = a[30:23];
  eb = b[30:23];
  fa = a[22:0];
  fb = b[22:0];
  flags = '0;
  nan_a = (ea == 8'hff) && (fa != '0);
  nan_b = (eb == 8'hff) && (fb != '0);
  inf_a = (ea == 8'hff) && (fa == '0);
  inf_b = (eb == 8'hff) && (fb == '0);
  // Subnormals count as zero
  zero_a = (ea == 8'h00);
  zero_b = (eb == 8'h00);

  // Special pairs in priority order
  if (nan_a || nan_b) begin
    // Only a signaling NaN raises invalid
    flags[fdiv_pkg::FLAG_NV] = (nan_a && !fa[22]) || (nan_b && !fb[22]);
    return {flags, 32'h7fc0_0000};
  end
  if ((inf_a && inf_b) || (zero_a && zero_b)) begin
    flags[fdiv_pkg::FLAG_NV] = 1'b1;
    return {flags, 32'h7fc0_0000};
  end
  if (inf_a) begin
    return {flags, sign, 8'hff, 23'h0};
  end
  if (inf_b) begin
    return {flags, sign, 31'h0};
  end
  if (zero_b) begin
    flags[fdiv_pkg::FLAG_DZ] = 1'b1;
    return {flags, sign, 8'hff, 23'h0};
  end
  if (zero_a) begin
    return {flags, sign, 31'h0};
  end

  // Quotient scaled by 2^25, plain integer long division
  num = 64'({1'b1, fa}) << 25;
  den = 64'({1'b1, fb});
  quot = num / den;
  rem = num % den;
  exp_val = int'(ea) - int'(eb) + 127;
  if (!quot[25]) begin
    quot = quot << 1;
    exp_val = exp_val - 1;
  end
  mant = quot[25:2];
  guard = quot[1];
  sticky = quot[0] || (rem != '0);

  case (rm)
    3'd1: inc = 1'b0;
    3'd2: inc = sign && (guard || sticky);
    3'd3: inc = !sign && (guard || sticky);
    3'd4: inc = guard;
    // Nearest even, also for codes 5 to 7
    default: inc = guard && (sticky || mant[0]);
  endcase
  sum = {1'b0, mant} + 25'(inc);
  if (sum[24]) begin
    mant = sum[24:1];
    exp_val = exp_val + 1;
  end else begin
    mant = sum[23:0];
  end

  if (exp_val >= 255) begin
    to_max = (rm == 3'd1) || ((rm == 3'd2) && !sign) || ((rm == 3'd3) && sign);
    flags[fdiv_pkg::FLAG_OF] = 1'b1;
    flags[fdiv_pkg::FLAG_NX] = 1'b1;
    return to_max ? {flags, sign, 8'hfe, 23'h7f_ffff} : {flags, sign, 8'hff, 23'h0};
  end
  if (exp_val <= 0) begin
    flags[fdiv_pkg::FLAG_UF] = 1'b1;
    flags[fdiv_pkg::FLAG_NX] = 1'b1;
    return {flags, sign, 31'h0};
  end
  flags[fdiv_pkg::FLAG_NX] = guard || sticky;
  return {flags, sign, exp_val[7:0], mant[22:0]};
endfunction

`endif

/* tests/fdiv_tb.sv */
module fdiv_tb;

  localparam int NUM_DIRECTED = 22;
  localparam int NUM_RANDOM = 300;
  localparam int NUM_OPS = NUM_DIRECTED + NUM_RANDOM;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 32 + 100;
  localparam int LAT_SPECIAL = 3;
  localparam int LAT_NORMAL = 30;
  localparam logic [31:0] SEED = 32'ha81a;

  // {rounding mode, operand a, operand b}
  localparam logic [66:0] DIRECTED [NUM_DIRECTED] = '{
    {3'd0, 32'h7fc0_0000, 32'h3f80_0000},  // Quiet NaN
    {3'd0, 32'h7f80_0001, 32'h3f80_0000},  // Signaling NaN in a
    {3'd1, 32'h3f80_0000, 32'hff80_0001},  // Signaling NaN in b
    {3'd0, 32'h7f80_0000, 32'hff80_0000},  // inf / inf
    {3'd3, 32'h0000_0000, 32'h8000_0000},  // 0 / 0
    {3'd0, 32'hff80_0000, 32'h4000_0000},  // inf / x
    {3'd2, 32'h4040_0000, 32'hff80_0000},  // x / inf
    {3'd0, 32'hc000_0000, 32'h0000_0000},  // x / 0
    {3'd4, 32'h8000_0000, 32'h4000_0000},  // 0 / x
    {3'd0, 32'h40c0_0000, 32'h4040_0000},  // 6 / 3 exact
    {3'd2, 32'h3f80_0000, 32'h4080_0000},  // 1 / 4 exact
    {3'd0, 32'h0000_0001, 32'h4000_0000},  // Subnormal over x
    {3'd0, 32'h3f80_0000, 32'h807f_ffff},  // x over subnormal
    {3'd0, 32'h7f00_0000, 32'h0080_0000},  // Overflow under RNE
    {3'd1, 32'h7f00_0000, 32'h0080_0000},  // Overflow under RTZ
    {3'd2, 32'h7f00_0000, 32'h0080_0000},  // Positive overflow under RDN
    {3'd3, 32'h7f00_0000, 32'h0080_0000},  // Positive overflow under RUP
    {3'd2, 32'hff00_0000, 32'h0080_0000},  // Negative overflow under RDN
    {3'd3, 32'hff00_0000, 32'h0080_0000},  // Negative overflow under RUP
    {3'd0, 32'h0080_0000, 32'h7f00_0000},  // Flush to +0
    {3'd3, 32'h8080_0000, 32'h7f00_0000},  // Flush to -0
    {3'd4, 32'h3f80_0000, 32'h4040_0000}   // 1 / 3 inexact
  };

  logic i_clk;
  logic i_rst;
  logic i_valid;
  logic [31:0] i_operand_a;
  logic [31:0] i_operand_b;
  logic [2:0] i_rounding_mode;
  logic [31:0] o_result;
  logic o_valid;
  logic o_stall;
  logic [4:0] o_flags;

  // Handshake model updated on the clock edge
  logic pending;
  logic valid_expected;
  int edge_cnt;
  int exp_lat;
  logic [31:0] exp_result;
  logic [4:0] exp_flags;
  logic pre_first_op;
  logic [31:0] lfsr_state;
  int cycle_count = 0;

  `include "fdiv_ref.svh"

  fdiv_top u_dut (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_valid(i_valid),
    .i_operand_a(i_operand_a),
    .i_operand_b(i_operand_b),
    .i_rounding_mode(i_rounding_mode),
    .o_result(o_result),
    .o_valid(o_valid),
    .o_stall(o_stall),
    .o_flags(o_flags)
  );

  always #4 i_clk = ~i_clk;

  // ==============================
  // Failure reporting
  // ==============================

  task automatic stop_on_failure();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string what);
    $display("** Error at time %0t: %s", $time, what);
    stop_on_failure();
  endtask

  // ==============================
  // Random source
  // ==============================

  // Right-shifting Galois form with taps 32 31 29 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'hd000_0001) : (state >> 1);
  endfunction

  task automatic take_random_bits(input int n, output logic [31:0] value);
    int k;
    value = '0;
    for (k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  // Exponents 64 to 191 keep most quotients in range
  task automatic make_random_operand(output logic [31:0] value);
    logic [31:0] s;
    logic [31:0] e;
    logic [31:0] f;
    take_random_bits(1, s);
    take_random_bits(7, e);
    take_random_bits(23, f);
    value = {s[0], 8'd64 + {1'b0, e[6:0]}, f[22:0]};
  endtask

  // Request held until the result pulse
  task automatic apply_operation(input logic [31:0] a, input logic [31:0] b,
                                 input logic [2:0] rm);
    i_operand_a = a;
    i_operand_b = b;
    i_rounding_mode = rm;
    i_valid = 1'b1;
    @(posedge i_clk);
    #1;
    while (!o_valid) begin
      @(posedge i_clk);
      #1;
    end
    i_valid = 1'b0;
  endtask

  // ==============================
  // Expected behavior
  // ==============================

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pending <= 1'b0;
      valid_expected <= 1'b0;
      edge_cnt <= 0;
      exp_lat <= 0;
    end else begin
      valid_expected <= pending && (edge_cnt + 1 == exp_lat);
      if (pending) begin
        edge_cnt <= edge_cnt + 1;
        if (edge_cnt + 1 == exp_lat) begin
          pending <= 1'b0;
        end
      end else if (i_valid) begin
        // Expected values are fixed at the accept edge
        pending <= 1'b1;
        edge_cnt <= 0;
        exp_lat <= is_special_pair(i_operand_a, i_operand_b) ? LAT_SPECIAL : LAT_NORMAL;
        {exp_flags, exp_result} <= divide_reference(i_operand_a, i_operand_b,
                                                    i_rounding_mode);
      end
    end
  end

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_on_failure();
    end
  end

  // ==============================
  // Checks
  // ==============================

  a_reset_values: assert property (@(posedge i_clk) disable iff (i_rst)
    pre_first_op |-> (!o_valid && o_flags == '0 && o_result == '0))
    else report_mismatch("outputs not zero after reset");

  a_stall_rule: assert property (@(posedge i_clk) disable iff (i_rst)
    o_stall == ((pending || i_valid) && !valid_expected))
    else report_mismatch($sformatf("o_stall is %b", $sampled(o_stall)));

  // Exact latency and a one-cycle pulse
  a_valid_timing: assert property (@(posedge i_clk) disable iff (i_rst)
    o_valid == valid_expected)
    else report_mismatch($sformatf("o_valid is %b, expected %b",
                                   $sampled(o_valid), $sampled(valid_expected)));

  a_result_value: assert property (@(posedge i_clk) disable iff (i_rst)
    o_valid |-> (o_result == exp_result && o_flags == exp_flags))
    else report_mismatch($sformatf("result %h flags %b, expected %h flags %b",
                                   $sampled(o_result), $sampled(o_flags),
                                   $sampled(exp_result), $sampled(exp_flags)));

  a_result_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    !o_valid |-> ($stable(o_result) && $stable(o_flags)))
    else report_mismatch("o_result or o_flags changed without o_valid");

  // ==============================
  // Stimulus
  // ==============================

  initial begin
    int i;
    logic [31:0] rand_a;
    logic [31:0] rand_b;
    logic [31:0] bits;
    i_clk = 1'b0;
    i_rst = 1'b1;
    i_valid = 1'b0;
    i_operand_a = '0;
    i_operand_b = '0;
    i_rounding_mode = '0;
    pre_first_op = 1'b1;
    lfsr_state = SEED;
    repeat (10) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    // Idle cycles to look at the reset values
    repeat (3) begin
      @(posedge i_clk);
      #1;
    end
    pre_first_op = 1'b0;

    for (i = 0; i < NUM_DIRECTED; i++) begin
      apply_operation(DIRECTED[i][63:32], DIRECTED[i][31:0], DIRECTED[i][66:64]);
    end

    for (i = 0; i < NUM_RANDOM; i++) begin
      make_random_operand(rand_a);
      make_random_operand(rand_b);
      // Reserved codes 5 to 7 act as RNE
      take_random_bits(3, bits);
      apply_operation(rand_a, rand_b, bits[2:0]);
      take_random_bits(1, bits);
      if (bits[0]) begin
        @(posedge i_clk);
        #1;
      end
    end

    repeat (4) begin
      @(posedge i_clk);
      #1;
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+tests
src/fdiv_pkg.sv
src/fdiv_classify.sv
src/fdiv_mant_divider.sv
src/fdiv_round_pack.sv
src/fdiv_ctrl.sv
src/fdiv_top.sv
tests/fdiv_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := fdiv_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only if the run printed the pass line
run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
